/* include/axi_defs.svh */
`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// Bus widths
`define AXI_ID_BITS 4
`define AXI_IDS_BITS 5
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4

// Memory depth and address map
`define SRAM_WORDS 1024
`define SLAVE_SEL_BIT 16
`define DECODE_MASK_HI 32'hfffe_0000

// Response codes
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10
`define AXI_RESP_DECERR 2'b11

`endif

/* project.f */
+incdir+include
src/axi_pkg.sv
src/cpu_port_bridge.sv
src/axi_interconnect.sv
src/sram_wrapper.sv
src/soc_top.sv
test/tb_soc.sv

/* run.sh */
#!/bin/sh
# Build and run the SoC testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_soc -f project.f

./obj_dir/Vtb_soc +verilator+rand+reset+0 2>&1 | tee sim.log

if grep -qx "Done: no errors" sim.log; then
  exit 0
fi
exit 1

/* src/axi_interconnect.sv */
`timescale 1ns/1ps
`include "axi_defs.svh"

module axi_interconnect (
  input  logic clk,
  input  logic rst,
  // Read channels, indexed by master
  input  logic [1:0] m_ar_valid,
  output logic [1:0] m_ar_ready,
  input  axi_pkg::axi_ar_t [1:0] m_ar,
  output logic [1:0] m_r_valid,
  input  logic [1:0] m_r_ready,
  output axi_pkg::axi_r_t [1:0] m_r,
  // Write channels of master 1
  input  logic aw1_valid,
  output logic aw1_ready,
  input  axi_pkg::axi_ar_t aw1,
  input  logic w1_valid,
  output logic w1_ready,
  input  axi_pkg::axi_w_t w1,
  output logic b1_valid,
  input  logic b1_ready,
  output axi_pkg::axi_b_t b1,
  // Slave channels, indexed by slave
  output logic [1:0] s_ar_valid,
  input  logic [1:0] s_ar_ready,
  output axi_pkg::axi_ars_t [1:0] s_ar,
  input  logic [1:0] s_r_valid,
  output logic [1:0] s_r_ready,
  input  axi_pkg::axi_rs_t [1:0] s_r,
  output logic [1:0] s_aw_valid,
  input  logic [1:0] s_aw_ready,
  output axi_pkg::axi_ars_t [1:0] s_aw,
  output logic [1:0] s_w_valid,
  input  logic [1:0] s_w_ready,
  output axi_pkg::axi_w_t [1:0] s_w,
  input  logic [1:0] s_b_valid,
  output logic [1:0] s_b_ready,
  input  axi_pkg::axi_bs_t [1:0] s_b
);

  localparam int TAG = `AXI_IDS_BITS - 1;

  logic [1:0] rd_err;
  logic [1:0] rd_sel;
  logic [1:0][1:0] rd_req;
  logic [1:0] gnt;
  logic [1:0] gnt_q;
  logic [1:0] ar_wait;
  logic [1:0] lock;
  logic [1:0] last;
  logic wr_err;
  logic wr_sel;
  logic [1:0] de_busy;
  logic [1:0] de_wr;
  axi_pkg::axi_id_t [1:0] de_id;
  logic [1:0] de_rd_fire;
  logic de_wr_fire;
  logic [1:0] outstanding;
  logic [1:0] m_addr_fire;
  logic [1:0] m_resp_fire;

  // Read decode and round-robin per slave
  always_comb begin
    for (int m = 0; m < 2; m++) begin
      rd_err[m] = |(m_ar[m].addr & `DECODE_MASK_HI);
      rd_sel[m] = m_ar[m].addr[`SLAVE_SEL_BIT];
    end
    for (int s = 0; s < 2; s++) begin
      for (int m = 0; m < 2; m++) begin
        rd_req[s][m] = m_ar_valid[m] && !rd_err[m] && (rd_sel[m] == 1'(s));
      end
      // A stalled grant stays put until the slave takes it
      if (ar_wait[s]) begin
        gnt[s] = gnt_q[s];
      end else if (&rd_req[s]) begin
        gnt[s] = !last[s];
      end else begin
        gnt[s] = rd_req[s][1];
      end
      s_ar_valid[s] = !lock[s] && rd_req[s][gnt[s]];
      s_ar[s] = '{id: {gnt[s], m_ar[gnt[s]].id}, addr: m_ar[gnt[s]].addr};
    end
    for (int m = 0; m < 2; m++) begin
      if (rd_err[m]) begin
        m_ar_ready[m] = !de_busy[m];
      end else begin
        m_ar_ready[m] = s_ar_ready[rd_sel[m]] && !lock[rd_sel[m]] && (gnt[rd_sel[m]] == 1'(m));
      end
      de_rd_fire[m] = m_ar_valid[m] && m_ar_ready[m] && rd_err[m];
    end
  end

  // Write path, master 1 only
  assign wr_err = |(aw1.addr & `DECODE_MASK_HI);
  assign wr_sel = aw1.addr[`SLAVE_SEL_BIT];
  assign aw1_ready = wr_err ? (!de_busy[1] && w1_valid) : s_aw_ready[wr_sel];
  assign w1_ready = wr_err ? (!de_busy[1] && aw1_valid) : s_w_ready[wr_sel];
  assign de_wr_fire = aw1_valid && aw1_ready && wr_err;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      s_aw_valid[s] = aw1_valid && !wr_err && (wr_sel == 1'(s));
      s_w_valid[s] = w1_valid && !wr_err && (wr_sel == 1'(s));
      s_aw[s] = '{id: {1'b1, aw1.id}, addr: aw1.addr};
      s_w[s] = w1;
    end
  end

  // Responses go back by the tag bit, decode errors from the local responder
  always_comb begin
    for (int m = 0; m < 2; m++) begin
      m_r_valid[m] = de_busy[m] && !de_wr[m];
      m_r[m] = '{id: de_id[m], data: '0, resp: `AXI_RESP_DECERR};
      for (int s = 0; s < 2; s++) begin
        if (s_r_valid[s] && s_r[s].id[TAG] == 1'(m)) begin
          m_r_valid[m] = 1'b1;
          m_r[m] = '{id: s_r[s].id[`AXI_ID_BITS-1:0], data: s_r[s].data, resp: s_r[s].resp};
        end
      end
    end
    b1_valid = de_busy[1] && de_wr[1];
    b1 = '{id: de_id[1], resp: `AXI_RESP_DECERR};
    for (int s = 0; s < 2; s++) begin
      s_r_ready[s] = m_r_ready[s_r[s].id[TAG]];
      s_b_ready[s] = b1_ready;
      if (s_b_valid[s]) begin
        b1_valid = 1'b1;
        b1 = '{id: s_b[s].id[`AXI_ID_BITS-1:0], resp: s_b[s].resp};
      end
    end
  end

  assign m_addr_fire = (m_ar_valid & m_ar_ready) | {aw1_valid && aw1_ready, 1'b0};
  assign m_resp_fire = (m_r_valid & m_r_ready) | {b1_valid && b1_ready, 1'b0};

  always_ff @(posedge clk) begin
    if (rst) begin
      lock <= '0;
      last <= '0;
      ar_wait <= '0;
      de_busy <= '0;
      outstanding <= '0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        ar_wait[s] <= s_ar_valid[s] && !s_ar_ready[s];
        if (s_r_valid[s] && s_r_ready[s]) begin
          lock[s] <= 1'b0;
        end
        if (s_ar_valid[s] && s_ar_ready[s]) begin
          lock[s] <= 1'b1;
          last[s] <= gnt[s];
        end
      end
      for (int m = 0; m < 2; m++) begin
        if (de_busy[m] && (de_wr[m] ? b1_ready : m_r_ready[m])) begin
          de_busy[m] <= 1'b0;
        end
        if (de_rd_fire[m] || (m == 1 && de_wr_fire)) begin
          de_busy[m] <= 1'b1;
        end
        if (m_resp_fire[m]) begin
          outstanding[m] <= 1'b0;
        end
        if (m_addr_fire[m]) begin
          outstanding[m] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    gnt_q <= gnt;
    for (int m = 0; m < 2; m++) begin
      if (de_rd_fire[m]) begin
        de_wr[m] <= 1'b0;
        de_id[m] <= m_ar[m].id;
      end
    end
    if (de_wr_fire) begin
      de_wr[1] <= 1'b1;
      de_id[1] <= aw1.id;
    end
  end

  // A slave answers only a master that is waiting
  for (genvar s = 0; s < 2; s++) begin : g_tag_chk
    assert property (@(posedge clk) disable iff (rst)
      s_r_valid[s] |-> outstanding[s_r[s].id[TAG]]);
    assert property (@(posedge clk) disable iff (rst)
      s_b_valid[s] |-> outstanding[s_b[s].id[TAG]]);
  end

endmodule

/* src/axi_pkg.sv */
`include "axi_defs.svh"

package axi_pkg;

  typedef logic [`AXI_ID_BITS-1:0] axi_id_t;
  typedef logic [`AXI_IDS_BITS-1:0] axi_ids_t;
  typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;
  typedef logic [`AXI_STRB_BITS-1:0] axi_strb_t;
  typedef logic [1:0] axi_resp_t;

  // Address channel, AR and AW alike
  typedef struct packed {
    axi_id_t id;
    axi_addr_t addr;
  } axi_ar_t;

  typedef struct packed {
    axi_ids_t id;
    axi_addr_t addr;
  } axi_ars_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  typedef struct packed {
    axi_id_t id;
    axi_data_t data;
    axi_resp_t resp;
  } axi_r_t;

  typedef struct packed {
    axi_ids_t id;
    axi_data_t data;
    axi_resp_t resp;
  } axi_rs_t;

  typedef struct packed {
    axi_id_t id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_ids_t id;
    axi_resp_t resp;
  } axi_bs_t;

  // Pipeline stage side
  typedef struct packed {
    logic we;
    axi_addr_t addr;
    axi_data_t wdata;
    axi_strb_t wstrb;
  } cpu_req_t;

  typedef struct packed {
    axi_data_t rdata;
    axi_resp_t resp;
  } cpu_rsp_t;

  typedef enum logic [1:0] {BR_IDLE, BR_ADDR, BR_DATA, BR_RESP} bridge_state_e;
  typedef enum logic [1:0] {SR_IDLE, SR_RDATA, SR_BRESP} sram_state_e;

endpackage

/* src/cpu_port_bridge.sv */
`timescale 1ns/1ps
`include "axi_defs.svh"

module cpu_port_bridge #(
  parameter bit HAS_WRITE = 1'b1
) (
  input  logic clk,
  input  logic rst,
  input  logic req,
  input  axi_pkg::cpu_req_t req_data,
  output logic busy,
  output logic done,
  output axi_pkg::cpu_rsp_t rsp,
  output logic ar_valid,
  input  logic ar_ready,
  output axi_pkg::axi_ar_t ar,
  input  logic r_valid,
  output logic r_ready,
  input  axi_pkg::axi_r_t r,
  output logic aw_valid,
  input  logic aw_ready,
  output axi_pkg::axi_ar_t aw,
  output logic w_valid,
  input  logic w_ready,
  output axi_pkg::axi_w_t w,
  input  logic b_valid,
  output logic b_ready,
  input  axi_pkg::axi_b_t b
);

  axi_pkg::bridge_state_e state;
  axi_pkg::cpu_req_t req_q;
  logic is_write;
  logic addr_fire;
  logic r_fire;
  logic b_fire;

  assign is_write = HAS_WRITE && req_q.we;
  assign busy = (state != axi_pkg::BR_IDLE);
  assign done = (state == axi_pkg::BR_RESP);

  assign ar_valid = (state == axi_pkg::BR_ADDR) && !is_write;
  assign ar = '{id: '0, addr: req_q.addr};
  // Never stall a response
  assign r_ready = 1'b1;

  assign r_fire = r_valid && r_ready;
  assign b_fire = b_valid && b_ready;
  assign addr_fire = (ar_valid && ar_ready) || (aw_valid && aw_ready && w_valid && w_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= axi_pkg::BR_IDLE;
    end else begin
      case (state)
        axi_pkg::BR_IDLE: if (req) state <= axi_pkg::BR_ADDR;
        axi_pkg::BR_ADDR: if (addr_fire) state <= axi_pkg::BR_DATA;
        axi_pkg::BR_DATA: if (r_fire || b_fire) state <= axi_pkg::BR_RESP;
        default: state <= axi_pkg::BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == axi_pkg::BR_IDLE && req) begin
      req_q <= req_data;
    end
    if (state == axi_pkg::BR_DATA && r_fire) begin
      rsp <= '{rdata: r.data, resp: r.resp};
    end else if (state == axi_pkg::BR_DATA && b_fire) begin
      rsp <= '{rdata: '0, resp: b.resp};
    end
  end

  generate
    if (HAS_WRITE) begin : g_write
      // AW and W leave together
      assign aw_valid = (state == axi_pkg::BR_ADDR) && is_write;
      assign w_valid = aw_valid;
      assign aw = '{id: '0, addr: req_q.addr};
      assign w = '{data: req_q.wdata, strb: req_q.wstrb};
      assign b_ready = 1'b1;

      // The fabric must take AW and W in the same cycle
      assert property (@(posedge clk) disable iff (rst) aw_valid && aw_ready |-> w_ready);
    end else begin : g_no_write
      assign aw_valid = 1'b0;
      assign w_valid = 1'b0;
      assign aw = '0;
      assign w = '0;
      assign b_ready = 1'b0;

      assert property (@(posedge clk) disable iff (rst) req |-> !req_data.we);
    end
  endgenerate

  assert property (@(posedge clk) disable iff (rst) req |-> !busy);

endmodule

/* src/soc_top.sv */
`timescale 1ns/1ps
`include "axi_defs.svh"

module soc_top (
  input  logic clk,
  input  logic rst,
  input  logic if_req,
  input  axi_pkg::cpu_req_t if_req_data,
  output logic if_busy,
  output logic if_done,
  output axi_pkg::cpu_rsp_t if_rsp,
  input  logic dm_req,
  input  axi_pkg::cpu_req_t dm_req_data,
  output logic dm_busy,
  output logic dm_done,
  output axi_pkg::cpu_rsp_t dm_rsp
);

  // Master 0 is the fetch port, master 1 the data port
  logic [1:0] m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
  axi_pkg::axi_ar_t [1:0] m_ar;
  axi_pkg::axi_r_t [1:0] m_r;
  logic aw1_valid, aw1_ready, w1_valid, w1_ready, b1_valid, b1_ready;
  axi_pkg::axi_ar_t aw1;
  axi_pkg::axi_w_t w1;
  axi_pkg::axi_b_t b1;

  // Slave 0 is the instruction SRAM, slave 1 the data SRAM
  logic [1:0] s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
  logic [1:0] s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
  axi_pkg::axi_ars_t [1:0] s_ar;
  axi_pkg::axi_ars_t [1:0] s_aw;
  axi_pkg::axi_rs_t [1:0] s_r;
  axi_pkg::axi_w_t [1:0] s_w;
  axi_pkg::axi_bs_t [1:0] s_b;

  cpu_port_bridge #(.HAS_WRITE(1'b0)) u_if_bridge (
    .clk(clk),
    .rst(rst),
    .req(if_req),
    .req_data(if_req_data),
    .busy(if_busy),
    .done(if_done),
    .rsp(if_rsp),
    .ar_valid(m_ar_valid[0]),
    .ar_ready(m_ar_ready[0]),
    .ar(m_ar[0]),
    .r_valid(m_r_valid[0]),
    .r_ready(m_r_ready[0]),
    .r(m_r[0]),
    .aw_valid(),
    .aw_ready(1'b0),
    .aw(),
    .w_valid(),
    .w_ready(1'b0),
    .w(),
    .b_valid(1'b0),
    .b_ready(),
    .b('0)
  );

  cpu_port_bridge #(.HAS_WRITE(1'b1)) u_dm_bridge (
    .clk(clk),
    .rst(rst),
    .req(dm_req),
    .req_data(dm_req_data),
    .busy(dm_busy),
    .done(dm_done),
    .rsp(dm_rsp),
    .ar_valid(m_ar_valid[1]),
    .ar_ready(m_ar_ready[1]),
    .ar(m_ar[1]),
    .r_valid(m_r_valid[1]),
    .r_ready(m_r_ready[1]),
    .r(m_r[1]),
    .aw_valid(aw1_valid),
    .aw_ready(aw1_ready),
    .aw(aw1),
    .w_valid(w1_valid),
    .w_ready(w1_ready),
    .w(w1),
    .b_valid(b1_valid),
    .b_ready(b1_ready),
    .b(b1)
  );

  axi_interconnect u_axi (
    .*
  );

  sram_wrapper u_im (
    .clk(clk),
    .rst(rst),
    .aw_valid(s_aw_valid[0]),
    .aw_ready(s_aw_ready[0]),
    .aw(s_aw[0]),
    .w_valid(s_w_valid[0]),
    .w_ready(s_w_ready[0]),
    .w(s_w[0]),
    .b_valid(s_b_valid[0]),
    .b_ready(s_b_ready[0]),
    .b(s_b[0]),
    .ar_valid(s_ar_valid[0]),
    .ar_ready(s_ar_ready[0]),
    .ar(s_ar[0]),
    .r_valid(s_r_valid[0]),
    .r_ready(s_r_ready[0]),
    .r(s_r[0])
  );

  sram_wrapper u_dm (
    .clk(clk),
    .rst(rst),
    .aw_valid(s_aw_valid[1]),
    .aw_ready(s_aw_ready[1]),
    .aw(s_aw[1]),
    .w_valid(s_w_valid[1]),
    .w_ready(s_w_ready[1]),
    .w(s_w[1]),
    .b_valid(s_b_valid[1]),
    .b_ready(s_b_ready[1]),
    .b(s_b[1]),
    .ar_valid(s_ar_valid[1]),
    .ar_ready(s_ar_ready[1]),
    .ar(s_ar[1]),
    .r_valid(s_r_valid[1]),
    .r_ready(s_r_ready[1]),
    .r(s_r[1])
  );

endmodule

/* src/sram_wrapper.sv */
`timescale 1ns/1ps
`include "axi_defs.svh"

module sram_wrapper (
  input  logic clk,
  input  logic rst,
  input  logic aw_valid,
  output logic aw_ready,
  input  axi_pkg::axi_ars_t aw,
  input  logic w_valid,
  output logic w_ready,
  input  axi_pkg::axi_w_t w,
  output logic b_valid,
  input  logic b_ready,
  output axi_pkg::axi_bs_t b,
  input  logic ar_valid,
  output logic ar_ready,
  input  axi_pkg::axi_ars_t ar,
  output logic r_valid,
  input  logic r_ready,
  output axi_pkg::axi_rs_t r
);

  localparam int IDX_BITS = $clog2(`SRAM_WORDS);

  axi_pkg::sram_state_e state;
  axi_pkg::axi_data_t mem [`SRAM_WORDS];
  logic rd_fire;
  logic wr_fire;
  logic rd_err;
  logic wr_err;
  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;

  // Reads first, AW and W only as a pair
  assign ar_ready = (state == axi_pkg::SR_IDLE);
  assign aw_ready = (state == axi_pkg::SR_IDLE) && !ar_valid && w_valid;
  assign w_ready = (state == axi_pkg::SR_IDLE) && !ar_valid && aw_valid;
  assign rd_fire = ar_valid && ar_ready;
  assign wr_fire = aw_valid && aw_ready;

  assign rd_idx = ar.addr[IDX_BITS+1:2];
  assign wr_idx = aw.addr[IDX_BITS+1:2];
  // Holes above the array inside the slave window
  assign rd_err = |ar.addr[`SLAVE_SEL_BIT-1:IDX_BITS+2];
  assign wr_err = |aw.addr[`SLAVE_SEL_BIT-1:IDX_BITS+2];

  assign r_valid = (state == axi_pkg::SR_RDATA);
  assign b_valid = (state == axi_pkg::SR_BRESP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= axi_pkg::SR_IDLE;
    end else begin
      case (state)
        axi_pkg::SR_IDLE: begin
          if (rd_fire) begin
            state <= axi_pkg::SR_RDATA;
          end else if (wr_fire) begin
            state <= axi_pkg::SR_BRESP;
          end
        end
        axi_pkg::SR_RDATA: if (r_ready) state <= axi_pkg::SR_IDLE;
        axi_pkg::SR_BRESP: if (b_ready) state <= axi_pkg::SR_IDLE;
        default: state <= axi_pkg::SR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      r.id <= ar.id;
      r.data <= rd_err ? '0 : mem[rd_idx];
      r.resp <= rd_err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
    end
    if (wr_fire) begin
      b.id <= aw.id;
      b.resp <= wr_err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
    end
  end

  // Byte lanes
  always_ff @(posedge clk) begin
    if (wr_fire && !wr_err) begin
      for (int i = 0; i < `AXI_STRB_BITS; i++) begin
        if (w.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

/* test/tb_soc.sv */
`timescale 1ns/1ps
`include "axi_defs.svh"

module tb_soc;

  localparam int RESET_CYCLES = 8;
  // 1 + 12 + 4 + 7 + 12 + 40 accesses over the six tests
  localparam int TOTAL_ACCESSES = 76;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * TOTAL_ACCESSES;
  localparam axi_pkg::axi_addr_t IM_BASE = 32'h0;
  localparam axi_pkg::axi_addr_t DM_BASE = 32'h1 << `SLAVE_SEL_BIT;

  logic clk;
  logic rst;
  logic if_req;
  axi_pkg::cpu_req_t if_req_data;
  logic if_busy;
  logic if_done;
  axi_pkg::cpu_rsp_t if_rsp;
  logic dm_req;
  axi_pkg::cpu_req_t dm_req_data;
  logic dm_busy;
  logic dm_done;
  axi_pkg::cpu_rsp_t dm_rsp;

  // Expected contents of both SRAMs, index 0 is the instruction SRAM
  axi_pkg::axi_data_t model_mem [2][`SRAM_WORDS];
  logic [31:0] lfsr;
  int data_errs;
  int resp_errs;
  int timing_errs;

  soc_top u_soc_top (
    .clk(clk),
    .rst(rst),
    .if_req(if_req),
    .if_req_data(if_req_data),
    .if_busy(if_busy),
    .if_done(if_done),
    .if_rsp(if_rsp),
    .dm_req(dm_req),
    .dm_req_data(dm_req_data),
    .dm_busy(dm_busy),
    .dm_done(dm_done),
    .dm_rsp(dm_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic axi_pkg::cpu_req_t make_read(input axi_pkg::axi_addr_t addr);
    return '{we: 1'b0, addr: addr, wdata: '0, wstrb: '0};
  endfunction

  function automatic axi_pkg::cpu_req_t make_write(input axi_pkg::axi_addr_t addr,
                                                    input axi_pkg::axi_data_t data,
                                                    input axi_pkg::axi_strb_t strb);
    return '{we: 1'b1, addr: addr, wdata: data, wstrb: strb};
  endfunction

  // Bits above 16 hit no slave, bits 15:12 fall in a hole of the SRAM window
  function automatic axi_pkg::axi_resp_t expected_resp(input axi_pkg::axi_addr_t addr);
    if (addr[31:17] != '0) begin
      return `AXI_RESP_DECERR;
    end else if (addr[15:12] != '0) begin
      return `AXI_RESP_SLVERR;
    end
    return `AXI_RESP_OKAY;
  endfunction

  function automatic axi_pkg::axi_data_t merge_bytes(input axi_pkg::axi_data_t old,
                                                     input axi_pkg::axi_data_t data,
                                                     input axi_pkg::axi_strb_t strb);
    axi_pkg::axi_data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
  endtask

  task automatic check_low(input string name, input logic value);
    if (value !== 1'b0) begin
      report_value(name, 32'(value), 32'd0);
      timing_errs++;
    end
  endtask

  // One request on a port, done and busy are sampled on the falling edge
  task automatic run_access(input int port, input axi_pkg::cpu_req_t rq,
                            output axi_pkg::cpu_rsp_t rsp, output int cycles);
    logic seen;
    logic busy_now;
    string bname;
    seen = 1'b0;
    cycles = 0;
    bname = (port == 0) ? "if_busy" : "dm_busy";
    @(posedge clk);
    if (port == 0) begin
      if_req <= 1'b1;
      if_req_data <= rq;
    end else begin
      dm_req <= 1'b1;
      dm_req_data <= rq;
    end
    while (!seen) begin
      @(negedge clk);
      cycles++;
      seen = (port == 0) ? if_done : dm_done;
      // Busy rises the cycle after req and stays up through done
      busy_now = (port == 0) ? if_busy : dm_busy;
      if (busy_now !== (cycles > 1)) begin
        report_value(bname, 32'(busy_now), 32'(cycles > 1));
        timing_errs++;
      end
      if (!seen) begin
        @(posedge clk);
        if (port == 0) begin
          if_req <= 1'b0;
        end else begin
          dm_req <= 1'b0;
        end
      end
    end
    rsp = (port == 0) ? if_rsp : dm_rsp;
  endtask

  task automatic check_access(input int port, input axi_pkg::cpu_req_t rq, output int cycles);
    axi_pkg::cpu_rsp_t rsp;
    axi_pkg::axi_resp_t exp_resp;
    axi_pkg::axi_data_t exp_data;
    string pname;
    exp_resp = expected_resp(rq.addr);
    exp_data = '0;
    if (!rq.we && exp_resp == `AXI_RESP_OKAY) begin
      exp_data = model_mem[rq.addr[`SLAVE_SEL_BIT]][rq.addr[11:2]];
    end
    run_access(port, rq, rsp, cycles);
    pname = (port == 0) ? "if_rsp" : "dm_rsp";
    if (rsp.resp !== exp_resp) begin
      report_value({pname, ".resp"}, 32'(rsp.resp), 32'(exp_resp));
      resp_errs++;
    end
    if (rsp.rdata !== exp_data) begin
      report_value({pname, ".rdata"}, rsp.rdata, exp_data);
      data_errs++;
    end
    if (rq.we && exp_resp == `AXI_RESP_OKAY) begin
      model_mem[rq.addr[`SLAVE_SEL_BIT]][rq.addr[11:2]] =
        merge_bytes(model_mem[rq.addr[`SLAVE_SEL_BIT]][rq.addr[11:2]], rq.wdata, rq.wstrb);
    end
  endtask

  task automatic test_reset_read();
    int cycles;
    @(negedge clk);
    check_low("if_busy", if_busy);
    check_low("if_done", if_done);
    check_low("dm_busy", dm_busy);
    check_low("dm_done", dm_done);
    check_access(1, make_read(DM_BASE | 32'h0ff0), cycles);
    if (cycles != 4) begin
      report_value("dm_done latency", 32'(cycles), 32'd4);
      timing_errs++;
    end
  endtask

  task automatic test_data_writes();
    int cycles;
    axi_pkg::axi_strb_t strbs [4];
    strbs = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    for (int i = 0; i < 4; i++) begin
      check_access(1, make_write(DM_BASE | 32'(i * 4), 32'h1122_3344 + 32'(i), 4'hf), cycles);
    end
    for (int i = 0; i < 4; i++) begin
      check_access(1, make_write(DM_BASE | 32'(i * 4), 32'hd5c6_b7a8, strbs[i]), cycles);
    end
    for (int i = 0; i < 4; i++) begin
      check_access(1, make_read(DM_BASE | 32'(i * 4)), cycles);
    end
  endtask

  task automatic test_instr_fetch();
    int cycles;
    check_access(1, make_write(IM_BASE | 32'h100, 32'h0000_0513, 4'hf), cycles);
    check_access(1, make_write(IM_BASE | 32'h104, 32'h00a5_8593, 4'b0011), cycles);
    check_access(0, make_read(IM_BASE | 32'h100), cycles);
    check_access(0, make_read(IM_BASE | 32'h104), cycles);
  endtask

  task automatic test_error_responses();
    int cycles;
    check_access(0, make_read(32'h0002_0010), cycles);
    check_access(1, make_read(32'h8001_0004), cycles);
    // Would alias IM word 0x40 if bit 17 were ignored
    check_access(1, make_write(32'h0002_0100, 32'hdead_beef, 4'hf), cycles);
    check_access(1, make_read(DM_BASE | 32'h1004), cycles);
    check_access(1, make_write(DM_BASE | 32'h3000, 32'hbad0_bad0, 4'hf), cycles);
    check_access(0, make_read(IM_BASE | 32'h100), cycles);
    check_access(1, make_read(DM_BASE), cycles);
  endtask

  // Same slave, same cycle, one slave holds one transaction
  task automatic test_contention();
    int c0;
    int c1;
    int win;
    int c_win;
    int c_lose;
    string wname;
    axi_pkg::axi_addr_t base;
    for (int r = 0; r < 6; r++) begin
      base = (r % 2 == 0) ? (IM_BASE | 32'h100) : DM_BASE;
      // The error test ends with a fetch read of the IM and a data read of the DM
      // Each loser is granted right after its winner and so the winner never changes
      win = (r % 2 == 0) ? 1 : 0;
      fork
        check_access(0, make_read(base | 32'((r % 2) * 8)), c0);
        check_access(1, make_read(base | 32'h4), c1);
      join
      c_win = (win == 0) ? c0 : c1;
      c_lose = (win == 0) ? c1 : c0;
      wname = (win == 0) ? "if_done latency" : "dm_done latency";
      if (c_win != 4) begin
        report_value(wname, 32'(c_win), 32'd4);
        timing_errs++;
      end
      if (c_lose <= 4) begin
        $display("Error at %0t ns: port %0d finished in %0d cycles without waiting for port %0d",
                 $time, 1 - win, c_lose, win);
        timing_errs++;
      end
    end
  endtask

  task automatic test_random_traffic();
    int c0;
    int c1;
    axi_pkg::cpu_req_t rq0;
    axi_pkg::cpu_req_t rq1;
    logic [31:0] idx;
    logic we;
    axi_pkg::axi_data_t data;
    axi_pkg::axi_strb_t strb;
    for (int i = 0; i < 20; i++) begin
      idx = take_bits(4);
      rq0 = make_read(IM_BASE | (idx << 2));
      idx = take_bits(4);
      we = take_bits(1) != 32'd0;
      data = take_bits(32);
      strb = 4'(take_bits(4));
      if (we) begin
        rq1 = make_write(DM_BASE | (idx << 2), data, strb);
      end else begin
        rq1 = make_read(DM_BASE | (idx << 2));
      end
      fork
        check_access(0, rq0, c0);
        check_access(1, rq1, c1);
      join
    end
  endtask

  initial begin
    rst = 1'b1;
    if_req = 1'b0;
    if_req_data = '0;
    dm_req = 1'b0;
    dm_req_data = '0;
    lfsr = 32'h71da;
    data_errs = 0;
    resp_errs = 0;
    timing_errs = 0;
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < `SRAM_WORDS; i++) begin
        model_mem[s][i] = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    test_reset_read();
    test_data_writes();
    test_instr_fetch();
    test_error_responses();
    test_contention();
    test_random_traffic();

    repeat (2) @(posedge clk);
    $display("Error counts: data %0d, response %0d, timing %0d",
             data_errs, resp_errs, timing_errs);
    if (data_errs + resp_errs + timing_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
